// File: design/dmmu.sv
// ====================
// Data MMU
// Translates load and store page numbers through a
// direct-mapped TLB, raises miss, page fault and uncached
// ====================

`timescale 1ns/10ps

module dmmu (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       re,
   input  logic                       we,
   input  logic [mmu_pkg::ADDR_W-1:0] vaddr,
   input  mmu_pkg::mode_t             mode,
   input  mmu_pkg::tlb_wr_t           tlb_wr,
   output mmu_pkg::xlat_t             xlat,
   output logic                       miss,
   output logic                       fault,
   output logic                       uncached
);

   logic [mmu_pkg::PN_W-1:0] vpn_in;
   logic [mmu_pkg::PN_W-1:0] vpn_q;
   logic [mmu_pkg::PAGE_W-1:0] off_q;
   logic [mmu_pkg::PN_W-1:0] ppn;
   logic req_q;
   logic en_q;
   logic rm_q;
   logic we_q;
   logic lo_we;
   logic hi_we;
   logic tlb_hit;
   logic perm_denied;
   logic unc_entry;
   logic unc_seg;
   mmu_pkg::tlb_lo_t lo_q;
   mmu_pkg::tlb_hi_t hi_q;

   assign vpn_in = vaddr[mmu_pkg::ADDR_W-1:mmu_pkg::PAGE_W];

   // Fill port decode, target 0 is this MMU
   assign lo_we = tlb_wr.stb & ~tlb_wr.tgt & ~tlb_wr.half;
   assign hi_we = tlb_wr.stb & ~tlb_wr.tgt & tlb_wr.half;

   // Request control state
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         req_q <= 1'b0;
         en_q <= 1'b0;
         rm_q <= 1'b0;
         we_q <= 1'b0;
      end
      else
      begin
         req_q <= re;
         if (re)
         begin
            en_q <= mode.dmme;
            rm_q <= mode.rm;
            we_q <= we;
         end
      end
   end

   // Request address fields
   always_ff @(posedge clk)
   begin
      if (re)
      begin
         vpn_q <= vpn_in;
         off_q <= vaddr[mmu_pkg::PAGE_W-1:0];
      end
   end

   // Tag and valid word
   tlb_ram #(.payload_t(mmu_pkg::tlb_lo_t)) i_tlb_lo (
      .clk   (clk),
      .rst_n (rst_n),
      .re    (re),
      .raddr (vpn_in[mmu_pkg::TLB_SETS_W-1:0]),
      .rdata (lo_q),
      .we    (lo_we),
      .waddr (tlb_wr.idx),
      .wdata (mmu_pkg::tlb_lo_t'(tlb_wr.data))
   );

   // Physical page and permission word
   tlb_ram #(.payload_t(mmu_pkg::tlb_hi_t)) i_tlb_hi (
      .clk   (clk),
      .rst_n (rst_n),
      .re    (re),
      .raddr (vpn_in[mmu_pkg::TLB_SETS_W-1:0]),
      .rdata (hi_q),
      .we    (hi_we),
      .waddr (tlb_wr.idx),
      .wdata (mmu_pkg::tlb_hi_t'(tlb_wr.data))
   );

   assign tlb_hit = lo_q.valid & (lo_q.vpn == vpn_q);

   // Root bits in root mode, user bits otherwise
   assign perm_denied = we_q ? ~(rm_q ? hi_q.rw : hi_q.uw)
                             : ~(rm_q ? hi_q.rr : hi_q.ur);

   // Fault only on a hit so the two never overlap
   assign miss = req_q & en_q & ~tlb_hit;
   assign fault = req_q & en_q & tlb_hit & perm_denied;

   // Identity map when disabled
   assign ppn = en_q ? hi_q.ppn : vpn_q;

   assign unc_entry = en_q & tlb_hit & ~perm_denied & hi_q.unc;
   // Segment rule holds for any clean access, mapped or not
   assign unc_seg = mmu_pkg::UNC_SEG_EN & ~miss & ~fault &
                    (ppn[mmu_pkg::PN_W-1 -: 4] == mmu_pkg::UNC_SEG_TAG);
   assign uncached = req_q & (unc_entry | unc_seg);

   always_comb
   begin
      xlat.valid = req_q & ~miss & ~fault;
      xlat.ppn = ppn;
      xlat.off = off_q;
      xlat.we = we_q;
      xlat.unc = uncached;
   end

endmodule

// File: design/immu.sv
// ====================
// Instruction MMU
// Translates fetch page numbers through a direct-mapped
// TLB and checks execute permission
// ====================

`timescale 1ns/10ps

module immu (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       re,
   input  logic [mmu_pkg::ADDR_W-1:0] vaddr,
   input  mmu_pkg::mode_t             mode,
   input  mmu_pkg::tlb_wr_t           tlb_wr,
   output mmu_pkg::xlat_t             xlat,
   output logic                       miss,
   output logic                       fault
);

   logic [mmu_pkg::PN_W-1:0] vpn_in;
   logic [mmu_pkg::PN_W-1:0] vpn_q;
   logic [mmu_pkg::PAGE_W-1:0] off_q;
   logic req_q;
   logic en_q;
   logic rm_q;
   logic lo_we;
   logic hi_we;
   logic tlb_hit;
   logic exec_ok;
   mmu_pkg::tlb_lo_t lo_q;
   mmu_pkg::tlb_hi_t hi_q;

   assign vpn_in = vaddr[mmu_pkg::ADDR_W-1:mmu_pkg::PAGE_W];

   // Fill port decode, target 1 is this MMU
   assign lo_we = tlb_wr.stb & tlb_wr.tgt & ~tlb_wr.half;
   assign hi_we = tlb_wr.stb & tlb_wr.tgt & tlb_wr.half;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         req_q <= 1'b0;
         en_q <= 1'b0;
         rm_q <= 1'b0;
      end
      else
      begin
         req_q <= re;
         if (re)
         begin
            en_q <= mode.imme;
            rm_q <= mode.rm;
         end
      end
   end

   // Fetch address fields
   always_ff @(posedge clk)
   begin
      if (re)
      begin
         vpn_q <= vpn_in;
         off_q <= vaddr[mmu_pkg::PAGE_W-1:0];
      end
   end

   tlb_ram #(.payload_t(mmu_pkg::tlb_lo_t)) i_tlb_lo (
      .clk   (clk),
      .rst_n (rst_n),
      .re    (re),
      .raddr (vpn_in[mmu_pkg::TLB_SETS_W-1:0]),
      .rdata (lo_q),
      .we    (lo_we),
      .waddr (tlb_wr.idx),
      .wdata (mmu_pkg::tlb_lo_t'(tlb_wr.data))
   );

   tlb_ram #(.payload_t(mmu_pkg::tlb_hi_t)) i_tlb_hi (
      .clk   (clk),
      .rst_n (rst_n),
      .re    (re),
      .raddr (vpn_in[mmu_pkg::TLB_SETS_W-1:0]),
      .rdata (hi_q),
      .we    (hi_we),
      .waddr (tlb_wr.idx),
      .wdata (mmu_pkg::tlb_hi_t'(tlb_wr.data))
   );

   assign tlb_hit = lo_q.valid & (lo_q.vpn == vpn_q);
   // Execute bit for the current privilege
   assign exec_ok = rm_q ? hi_q.rx : hi_q.ux;

   assign miss = req_q & en_q & ~tlb_hit;
   assign fault = req_q & en_q & tlb_hit & ~exec_ok;

   // Fetches never write and are always cacheable
   always_comb
   begin
      xlat.valid = req_q & ~miss & ~fault;
      xlat.ppn = en_q ? hi_q.ppn : vpn_q;
      xlat.off = off_q;
      xlat.we = 1'b0;
      xlat.unc = 1'b0;
   end

endmodule

// File: design/mmu_pkg.sv
// ====================
// MMU shared definitions
// Page geometry, TLB word layouts, fill command, mode bits
// and the physical bus request format
// ====================

package mmu_pkg;

   // Address and page geometry
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   // 8 KiB pages
   localparam int PAGE_W = 13;
   localparam int PN_W = 19;
   // 16 direct-mapped entries, index taken from low page number bits
   // Must not exceed PN_W
   localparam int TLB_SETS_W = 4;

   // Data side uncached segment rule
   localparam bit UNC_SEG_EN = 1'b1;
   localparam logic [3:0] UNC_SEG_TAG = 4'h8;

   // Low TLB word, tag on top and valid in bit 0
   typedef struct packed {
      logic [PN_W-1:0] vpn;
      logic [DATA_W-PN_W-2:0] rsvd;
      logic valid;
   } tlb_lo_t;

   // High TLB word, physical page on top and permissions below
   typedef struct packed {
      logic [PN_W-1:0] ppn;
      logic [DATA_W-PN_W-10:0] rsvd;
      logic s;
      logic unc;
      logic rr;
      logic rw;
      logic ur;
      logic uw;
      logic rx;
      logic ux;
      logic p;
   } tlb_hi_t;

   // Software TLB fill command
   typedef struct packed {
      logic stb;
      // 0 for data MMU, 1 for instruction MMU
      logic tgt;
      // 0 for low word, 1 for high word
      logic half;
      logic [TLB_SETS_W-1:0] idx;
      logic [DATA_W-1:0] data;
   } tlb_wr_t;

   // Processor mode levels
   typedef struct packed {
      logic dmme;
      logic imme;
      logic rm;
   } mode_t;

   // Physical bus request, src 0 for data and 1 for fetch
   typedef struct packed {
      logic valid;
      logic src;
      logic [PN_W-1:0] ppn;
      logic [PAGE_W-1:0] off;
      logic we;
      logic unc;
   } bus_req_t;

   // MMU result towards the arbiter
   typedef struct packed {
      logic valid;
      logic [PN_W-1:0] ppn;
      logic [PAGE_W-1:0] off;
      logic we;
      logic unc;
   } xlat_t;

endpackage

// File: design/mmu_top.sv
// ====================
// MMU subsystem top
// Data and instruction MMUs sharing one fill port
// and one arbitrated physical bus
// ====================

`timescale 1ns/10ps

module mmu_top (
   input  logic                       clk,
   input  logic                       rst_n,
   input  mmu_pkg::mode_t             mode,
   input  mmu_pkg::tlb_wr_t           tlb_wr,
   // Data side
   input  logic                       d_re,
   input  logic                       d_we,
   input  logic [mmu_pkg::ADDR_W-1:0] d_vaddr,
   // Fetch side
   input  logic                       f_re,
   input  logic [mmu_pkg::ADDR_W-1:0] f_vaddr,
   // Memory side
   output mmu_pkg::bus_req_t          bus,
   output logic                       d_busy,
   output logic                       f_busy,
   // Exceptions
   output logic                       d_miss,
   output logic                       d_fault,
   output logic                       d_uncached,
   output logic                       f_miss,
   output logic                       f_fault
);

   mmu_pkg::xlat_t d_xlat;
   mmu_pkg::xlat_t f_xlat;

   dmmu i_dmmu (
      .clk      (clk),
      .rst_n    (rst_n),
      .re       (d_re),
      .we       (d_we),
      .vaddr    (d_vaddr),
      .mode     (mode),
      .tlb_wr   (tlb_wr),
      .xlat     (d_xlat),
      .miss     (d_miss),
      .fault    (d_fault),
      .uncached (d_uncached)
   );

   immu i_immu (
      .clk    (clk),
      .rst_n  (rst_n),
      .re     (f_re),
      .vaddr  (f_vaddr),
      .mode   (mode),
      .tlb_wr (tlb_wr),
      .xlat   (f_xlat),
      .miss   (f_miss),
      .fault  (f_fault)
   );

   // Serializes both result streams onto the bus
   phys_arbiter i_arb (
      .clk    (clk),
      .rst_n  (rst_n),
      .d_xlat (d_xlat),
      .f_xlat (f_xlat),
      .bus    (bus),
      .d_busy (d_busy),
      .f_busy (f_busy)
   );

endmodule

// File: design/phys_arbiter.sv
// ====================
// Physical bus arbiter
// Round-robin grant of data and fetch results with a
// one-entry hold per side
// ====================

`timescale 1ns/10ps

module phys_arbiter (
   input  logic              clk,
   input  logic              rst_n,
   input  mmu_pkg::xlat_t    d_xlat,
   input  mmu_pkg::xlat_t    f_xlat,
   output mmu_pkg::bus_req_t bus,
   output logic              d_busy,
   output logic              f_busy
);

   mmu_pkg::xlat_t d_hold;
   mmu_pkg::xlat_t f_hold;
   mmu_pkg::xlat_t d_cand;
   mmu_pkg::xlat_t f_cand;
   mmu_pkg::xlat_t win;
   // 0 favours data, 1 favours fetch
   logic rr_ptr;
   logic d_gnt;
   logic f_gnt;

   // Next hold content for one side
   function automatic mmu_pkg::xlat_t hold_next(
      input mmu_pkg::xlat_t hold,
      input mmu_pkg::xlat_t fresh,
      input logic           gnt
   );
      mmu_pkg::xlat_t nxt;
      nxt = hold;
      if (!hold.valid)
      begin
         // Fresh loser parks here
         nxt = fresh;
         if (gnt)
         begin
            nxt.valid = 1'b0;
         end
      end
      else if (gnt)
      begin
         // Held entry leaves, a late fresh one takes its place
         nxt = fresh;
      end
      return nxt;
   endfunction

   // Held entries go ahead of fresh ones on the same side
   assign d_cand = d_hold.valid ? d_hold : d_xlat;
   assign f_cand = f_hold.valid ? f_hold : f_xlat;

   assign d_gnt = d_cand.valid & (~f_cand.valid | ~rr_ptr);
   assign f_gnt = f_cand.valid & ~d_gnt;
   assign win = f_gnt ? f_cand : d_cand;

   assign d_busy = d_hold.valid;
   assign f_busy = f_hold.valid;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         bus.valid <= 1'b0;
         d_hold.valid <= 1'b0;
         f_hold.valid <= 1'b0;
         rr_ptr <= 1'b0;
      end
      else
      begin
         bus.valid <= d_gnt | f_gnt;
         bus.src <= f_gnt;
         bus.ppn <= win.ppn;
         bus.off <= win.off;
         bus.we <= win.we;
         bus.unc <= win.unc;
         d_hold <= hold_next(d_hold, d_xlat, d_gnt);
         f_hold <= hold_next(f_hold, f_xlat, f_gnt);
         // Flip only after a contended grant
         if (d_cand.valid & f_cand.valid)
         begin
            rr_ptr <= ~rr_ptr;
         end
      end
   end

endmodule

// File: design/tlb_ram.sv
// ====================
// TLB storage
// Direct-mapped entry array, one write port
// and one registered read port
// ====================

`timescale 1ns/10ps

module tlb_ram #(
   parameter type payload_t = logic [mmu_pkg::DATA_W-1:0]
) (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          re,
   input  logic [mmu_pkg::TLB_SETS_W-1:0] raddr,
   output payload_t                      rdata,
   input  logic                          we,
   input  logic [mmu_pkg::TLB_SETS_W-1:0] waddr,
   input  payload_t                      wdata
);

   payload_t mem [0:(1 << mmu_pkg::TLB_SETS_W)-1];

   // Reset pass clears every entry so valid bits read zero
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < (1 << mmu_pkg::TLB_SETS_W); i++)
         begin
            mem[i] <= '0;
         end
      end
      else if (we)
      begin
         mem[waddr] <= wdata;
      end
   end

   // Registered read, old content on same-cycle write
   always_ff @(posedge clk)
   begin
      if (re)
      begin
         rdata <= mem[raddr];
      end
   end

endmodule

// File: mmu_top.f
design/mmu_pkg.sv
design/tlb_ram.sv
design/dmmu.sv
design/immu.sv
design/phys_arbiter.sv
design/mmu_top.sv
tb/mmu_clock_gen.sv
tb/mmu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the MMU testbench with Verilator, run it, and grade the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f mmu_top.f \
   --top-module mmu_tb -o mmu_sim > build.log 2>&1 \
   && ./obj_dir/mmu_sim > "$LOG" 2>&1 \
   || { echo "build or simulation run failed"; exit 1; }

grep -qF "*** PASSED ***" "$LOG" \
   && echo "simulation passed" \
   || { echo "simulation failed, see $LOG"; exit 1; }

// File: tb/mmu_clock_gen.sv
// ====================
// Testbench clock and reset
// 100 ns clock, reset held low for 10 cycles
// ====================

`timescale 1ns/10ps

module mmu_clock_gen (
   output logic clk,
   output logic rst_n
);

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Release just after an edge so the DUT sees a clean level
   initial
   begin
      rst_n = 1'b0;
      repeat (10) @(posedge clk);
      #1;
      rst_n = 1'b1;
   end

endmodule

// File: tb/mmu_stimulus.txt
# columns: op name f1 f2 f3 f4 f5 f6, fields in hex, unused fields 0
# M dmme imme rm | W tgt half idx data | I cycles | F vaddr miss fault paddr
# D we vaddr miss fault unc paddr | P d_we d_vaddr f_vaddr first_src d_paddr f_paddr
M set_mode_off 0 0 0 0 0 0
D off_data_read 0 00012345 0 0 0 00012345
D off_data_write 1 00031abc 0 0 0 00031abc
F off_fetch 00024680 0 0 00024680 0 0
M set_mode_user 1 1 0 0 0 0
D d_miss_invalid 0 00004000 1 0 0 00000000
F f_miss_invalid 00006000 1 0 00000000 0 0
W tlb_d5_lo 0 0 5 0002a001 0 0
W tlb_d5_hi 0 1 5 00246079 0 0
D d_hit_idx5 0 0002a1f4 0 0 0 002461f4
D d_miss_tag 0 0004a010 1 0 0 00000000
W tlb_d6_lo 0 0 6 0006c001 0 0
W tlb_d6_hi 0 1 6 004000f9 0 0
D d_hit_unc_entry 1 0006c008 0 0 1 00400008
W tlb_d7_lo 0 0 7 0000e001 0 0
W tlb_d7_hi 0 1 7 0068a071 0 0
D d_user_write_fault 1 0000e100 0 1 0 00000000
D d_user_read_ok 0 0000e104 0 0 0 0068a104
W tlb_i9_lo 1 0 9 00052001 0 0
W tlb_i9_hi 1 1 9 01578005 0 0
F f_user_exec_fault 00052040 0 1 00000000 0 0
M set_mode_root 1 1 1 0 0 0
D d_root_write_ok 1 0000e100 0 0 0 0068a100
F f_root_exec_ok 00052040 0 0 01578040 0 0
W tlb_d10_lo 0 0 a 00014001 0 0
W tlb_d10_hi 0 1 a 80002079 0 0
D d_unc_segment 0 00014abc 0 0 1 80002abc
I settle 2 0 0 0 0 0
P pair_data_first 0 0002a1f4 00052040 0 002461f4 01578040
I settle 2 0 0 0 0 0
P pair_fetch_first 1 0006c010 00052044 1 00400010 01578044
I drain 3 0 0 0 0 0

// File: tb/mmu_tb.sv
// ====================
// MMU subsystem testbench
// Replays the stimulus file against the DUT and checks
// exceptions, bus requests and arbitration order
// ====================

`timescale 1ns/10ps

module mmu_tb;

   logic clk;
   logic rst_n;
   mmu_pkg::mode_t mode;
   mmu_pkg::tlb_wr_t tlb_wr;
   logic d_re;
   logic d_we;
   logic [mmu_pkg::ADDR_W-1:0] d_vaddr;
   logic f_re;
   logic [mmu_pkg::ADDR_W-1:0] f_vaddr;
   mmu_pkg::bus_req_t bus;
   logic d_busy;
   logic f_busy;
   logic d_miss;
   logic d_fault;
   logic d_uncached;
   logic f_miss;
   logic f_fault;
   int n_tests;
   int n_failed;
   int n_errors;

   mmu_clock_gen i_clk_gen (
      .clk   (clk),
      .rst_n (rst_n)
   );

   mmu_top i_dut (
      .clk        (clk),
      .rst_n      (rst_n),
      .mode       (mode),
      .tlb_wr     (tlb_wr),
      .d_re       (d_re),
      .d_we       (d_we),
      .d_vaddr    (d_vaddr),
      .f_re       (f_re),
      .f_vaddr    (f_vaddr),
      .bus        (bus),
      .d_busy     (d_busy),
      .f_busy     (f_busy),
      .d_miss     (d_miss),
      .d_fault    (d_fault),
      .d_uncached (d_uncached),
      .f_miss     (f_miss),
      .f_fault    (f_fault)
   );

   // Inputs change and outputs are read 1 ns after the edge
   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic check_val(input string name, input string what,
                            input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp)
      else
      begin
         $display("[ERROR] %s %s expected %h actual %h", name, what, exp, act);
         n_errors++;
      end
   endtask

   // Bus request within 20 cycles or a timeout failure
   task automatic wait_bus(input string name, output bit seen);
      int cnt;
      seen = 1'b0;
      cnt = 0;
      while (!seen && cnt < 20)
      begin
         next_cycle();
         seen = (bus.valid === 1'b1);
         cnt++;
      end
      assert (seen)
      else
      begin
         $display("%s: no bus request came out within 20 cycles", name);
         n_errors++;
      end
   endtask

   // Failed translations must stay off the bus
   task automatic expect_no_bus(input string name);
      for (int i = 0; i < 3; i++)
      begin
         next_cycle();
         check_val(name, "bus valid", 32'd0, {31'd0, bus.valid});
      end
   endtask

   task automatic check_bus(input string name, input logic src, input logic [31:0] paddr,
                            input logic we, input logic unc);
      check_val(name, "bus src", {31'd0, src}, {31'd0, bus.src});
      check_val(name, "bus paddr", paddr, {bus.ppn, bus.off});
      check_val(name, "bus we", {31'd0, we}, {31'd0, bus.we});
      check_val(name, "bus unc", {31'd0, unc}, {31'd0, bus.unc});
   endtask

   task automatic finish_test(input string name, input int errs_before);
      n_tests++;
      if (n_errors == errs_before)
      begin
         $display("ok    %s", name);
      end
      else
      begin
         n_failed++;
         $display("fail  %s", name);
      end
   endtask

   task automatic run_data(input string name, input logic we, input logic [31:0] vaddr,
                           input logic exp_miss, input logic exp_fault, input logic exp_unc,
                           input logic [31:0] paddr);
      int errs;
      bit seen;
      errs = n_errors;
      d_re = 1'b1;
      d_we = we;
      d_vaddr = vaddr;
      next_cycle();
      // Exceptions are one-cycle pulses right after the strobe
      check_val(name, "d_miss", {31'd0, exp_miss}, {31'd0, d_miss});
      check_val(name, "d_fault", {31'd0, exp_fault}, {31'd0, d_fault});
      check_val(name, "d_uncached", {31'd0, exp_unc}, {31'd0, d_uncached});
      d_re = 1'b0;
      if (!exp_miss && !exp_fault)
      begin
         wait_bus(name, seen);
         if (seen)
         begin
            check_bus(name, 1'b0, paddr, we, exp_unc);
         end
      end
      else
      begin
         expect_no_bus(name);
      end
      finish_test(name, errs);
   endtask

   task automatic run_fetch(input string name, input logic [31:0] vaddr,
                            input logic exp_miss, input logic exp_fault,
                            input logic [31:0] paddr);
      int errs;
      bit seen;
      errs = n_errors;
      f_re = 1'b1;
      f_vaddr = vaddr;
      next_cycle();
      check_val(name, "f_miss", {31'd0, exp_miss}, {31'd0, f_miss});
      check_val(name, "f_fault", {31'd0, exp_fault}, {31'd0, f_fault});
      f_re = 1'b0;
      if (!exp_miss && !exp_fault)
      begin
         wait_bus(name, seen);
         if (seen)
         begin
            // Fetches never write and are never uncached
            check_bus(name, 1'b1, paddr, 1'b0, 1'b0);
         end
      end
      else
      begin
         expect_no_bus(name);
      end
      finish_test(name, errs);
   endtask

   // Both sides strobed together so the winner goes out before the held loser
   task automatic run_pair(input string name, input logic we, input logic [31:0] dva,
                           input logic [31:0] fva, input logic first,
                           input logic [31:0] d_paddr, input logic [31:0] f_paddr);
      int errs;
      bit seen;
      errs = n_errors;
      d_re = 1'b1;
      d_we = we;
      d_vaddr = dva;
      f_re = 1'b1;
      f_vaddr = fva;
      next_cycle();
      check_val(name, "exceptions", 32'd0, {28'd0, d_miss, d_fault, f_miss, f_fault});
      check_val(name, "busy before grant", 32'd0, {30'd0, d_busy, f_busy});
      d_re = 1'b0;
      f_re = 1'b0;
      wait_bus(name, seen);
      if (seen)
      begin
         check_val(name, "first src", {31'd0, first}, {31'd0, bus.src});
         check_val(name, "first paddr", first ? f_paddr : d_paddr, {bus.ppn, bus.off});
         // Only the data side writes
         check_val(name, "first we", {31'd0, first ? 1'b0 : we}, {31'd0, bus.we});
         // Loser busy only while its entry waits in the hold register
         check_val(name, "busy while held", first ? 32'd2 : 32'd1, {30'd0, d_busy, f_busy});
         next_cycle();
         check_val(name, "second valid", 32'd1, {31'd0, bus.valid});
         check_val(name, "second src", {31'd0, ~first}, {31'd0, bus.src});
         check_val(name, "second paddr", first ? d_paddr : f_paddr, {bus.ppn, bus.off});
         check_val(name, "second we", {31'd0, first ? we : 1'b0}, {31'd0, bus.we});
         check_val(name, "busy after grant", 32'd0, {30'd0, d_busy, f_busy});
      end
      finish_test(name, errs);
   endtask

   // One stimulus line holds opcode, name and six hex fields
   task automatic run_line(input string line);
      string op;
      string name;
      logic [31:0] f1;
      logic [31:0] f2;
      logic [31:0] f3;
      logic [31:0] f4;
      logic [31:0] f5;
      logic [31:0] f6;
      int code;
      code = $sscanf(line, "%s %s %h %h %h %h %h %h", op, name, f1, f2, f3, f4, f5, f6);
      if (code != 8)
      begin
         $display("a stimulus line could not be parsed: %s", line);
         n_errors++;
      end
      else
      begin
         case (op)
            "M":
            begin
               mode.dmme = f1[0];
               mode.imme = f2[0];
               mode.rm = f3[0];
               next_cycle();
            end
            "W":
            begin
               tlb_wr.stb = 1'b1;
               tlb_wr.tgt = f1[0];
               tlb_wr.half = f2[0];
               tlb_wr.idx = f3[mmu_pkg::TLB_SETS_W-1:0];
               tlb_wr.data = f4;
               next_cycle();
               tlb_wr.stb = 1'b0;
            end
            "D": run_data(name, f1[0], f2, f3[0], f4[0], f5[0], f6);
            "F": run_fetch(name, f1, f2[0], f3[0], f4);
            "P": run_pair(name, f1[0], f2, f3, f4[0], f5, f6);
            "I": repeat (f1) next_cycle();
            default:
            begin
               $display("unknown stimulus operation %s on test %s", op, name);
               n_errors++;
            end
         endcase
      end
   endtask

   initial
   begin
      int fd;
      int code;
      int cnt;
      string line;
      mode = '0;
      tlb_wr = '0;
      d_re = 1'b0;
      d_we = 1'b0;
      d_vaddr = '0;
      f_re = 1'b0;
      f_vaddr = '0;
      n_tests = 0;
      n_failed = 0;
      n_errors = 0;
      // Bounded wait for reset release, sampled on the edge
      cnt = 0;
      while (rst_n !== 1'b1 && cnt < 30)
      begin
         @(posedge clk);
         cnt++;
      end
      if (rst_n !== 1'b1)
      begin
         $display("reset never released");
         n_errors++;
      end
      next_cycle();
      fd = $fopen("tb/mmu_stimulus.txt", "r");
      if (fd == 0)
      begin
         $display("could not open the stimulus file");
         n_errors++;
      end
      else
      begin
         while (!$feof(fd))
         begin
            line = "";
            code = $fgets(line, fd);
            // Skip comments and blank lines
            if (code > 0 && line.len() > 1 && line.getc(0) != "#")
            begin
               run_line(line);
            end
         end
         $fclose(fd);
      end
      $display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, n_errors);
      if (n_errors == 0)
      begin
         $display("*** PASSED ***");
      end
      else
      begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule
